/* rtl/admm_params.svh */
`ifndef ADMM_PARAMS_SVH
`define ADMM_PARAMS_SVH

// Fixed-point data path
`define ADMM_DATA_W     16
`define ADMM_FRAC_BITS  8
`define ADMM_LANES      4
`define ADMM_MAX_ITER   32

// Host bus
`define ADMM_BUS_W      32
`define ADMM_ADDR_W     8
`define ADMM_FIELD_W    3

// Control region register numbers
`define ADMM_REG_CTRL   0
`define ADMM_REG_STATUS 1
`define ADMM_REG_ITER   2
`define ADMM_REG_TOL    3
`define ADMM_REG_RESID  4

// Lane region field numbers
`define ADMM_FLD_U      0
`define ADMM_FLD_UMIN   1
`define ADMM_FLD_UMAX   2
`define ADMM_FLD_Z      3
`define ADMM_FLD_Y      4

`endif

/* rtl/admm_pkg.sv */
`default_nettype none
`include "admm_params.svh"

package admm_pkg;

    // Signed Q7.8 value
    typedef logic signed [`ADMM_DATA_W-1:0] fix_t;

    localparam fix_t FIX_MAX = {1'b0, {(`ADMM_DATA_W-1){1'b1}}};
    localparam fix_t FIX_MIN = {1'b1, {(`ADMM_DATA_W-1){1'b0}}};

    // Host-written lane settings
    typedef struct packed {
        fix_t u;
        fix_t u_min;
        fix_t u_max;
    } lane_cfg_t;

    // Lane results, residual is |z_new - z_old|
    typedef struct packed {
        fix_t                    z;
        fix_t                    y;
        logic [`ADMM_DATA_W-1:0] residual;
    } lane_out_t;

    // Address as a lane access
    typedef struct packed {
        logic                                       region;
        logic [`ADMM_ADDR_W-2-`ADMM_FIELD_W:0]      index;
        logic [`ADMM_FIELD_W-1:0]                   field;
    } lane_addr_t;

    // Address as a control register access
    typedef struct packed {
        logic                   region;
        logic [`ADMM_ADDR_W-2:0] num;
    } ctrl_addr_t;

    typedef union packed {
        lane_addr_t lane;
        ctrl_addr_t ctrl;
    } reg_addr_u;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        STEP,
        WAIT,
        CHECK,
        DONE
    } solver_state_t;

endpackage

`default_nettype wire

/* rtl/admm_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "admm_params.svh"

module admm_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`ADMM_BUS_W-1:0]  writedata,
    input  logic                    read,
    input  logic                    write,
    input  logic                    chipselect,
    input  logic [`ADMM_ADDR_W-1:0] addr,
    output logic [`ADMM_BUS_W-1:0]  readdata,
    output admm_pkg::lane_cfg_t     cfg [`ADMM_LANES],
    input  admm_pkg::lane_out_t     lane_out [`ADMM_LANES],
    output admm_pkg::fix_t          tol,
    input  admm_pkg::fix_t          max_res,
    output logic                    start,
    input  logic                    done,
    input  logic                    converged,
    input  logic                    busy,
    input  logic [7:0]              iter
);
    import admm_pkg::*;

    localparam int SEL_W = $clog2(`ADMM_LANES);

    // Default tolerance of 1/16
    localparam fix_t TOL_RESET = fix_t'(1 << (`ADMM_FRAC_BITS - 4));

    reg_addr_u              a;
    logic                   wr_en;
    logic                   rd_en;
    logic                   lane_hit;
    logic [SEL_W-1:0]       lane_sel;
    fix_t                   wdata;
    fix_t                   ctrl;
    logic [`ADMM_BUS_W-1:0] rd_mux;

    function automatic logic [`ADMM_BUS_W-1:0] sext(fix_t v);
        return {{(`ADMM_BUS_W-`ADMM_DATA_W){v[`ADMM_DATA_W-1]}}, v};
    endfunction

    assign a        = addr;
    assign wr_en    = chipselect && write;
    assign rd_en    = chipselect && read;
    assign lane_hit = a.lane.region && (a.lane.index < `ADMM_LANES);
    assign lane_sel = a.lane.index[SEL_W-1:0];
    assign wdata    = writedata[`ADMM_DATA_W-1:0];
    assign start    = ctrl[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl <= '0;
            tol  <= TOL_RESET;
        end else if (wr_en && !a.ctrl.region) begin
            case (a.ctrl.num)
                `ADMM_REG_CTRL: ctrl <= wdata;
                `ADMM_REG_TOL:  tol  <= wdata;
                default: ;
            endcase
        end
    end

    // Lane settings stay frozen while a solve runs
    always_ff @(posedge clk) begin
        if (wr_en && lane_hit && !busy) begin
            case (a.lane.field)
                `ADMM_FLD_U:    cfg[lane_sel].u     <= wdata;
                `ADMM_FLD_UMIN: cfg[lane_sel].u_min <= wdata;
                `ADMM_FLD_UMAX: cfg[lane_sel].u_max <= wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_mux = '0;
        if (!a.ctrl.region) begin
            case (a.ctrl.num)
                `ADMM_REG_CTRL:   rd_mux = sext(ctrl);
                `ADMM_REG_STATUS: rd_mux = {{(`ADMM_BUS_W-3){1'b0}}, busy, converged, done};
                `ADMM_REG_ITER:   rd_mux = {{(`ADMM_BUS_W-8){1'b0}}, iter};
                `ADMM_REG_TOL:    rd_mux = sext(tol);
                `ADMM_REG_RESID:  rd_mux = sext(max_res);
                default:          rd_mux = '0;
            endcase
        end else if (lane_hit) begin
            case (a.lane.field)
                `ADMM_FLD_U:    rd_mux = sext(cfg[lane_sel].u);
                `ADMM_FLD_UMIN: rd_mux = sext(cfg[lane_sel].u_min);
                `ADMM_FLD_UMAX: rd_mux = sext(cfg[lane_sel].u_max);
                `ADMM_FLD_Z:    rd_mux = sext(lane_out[lane_sel].z);
                `ADMM_FLD_Y:    rd_mux = sext(lane_out[lane_sel].y);
                default:        rd_mux = '0;
            endcase
        end
    end

    // Read data lands one cycle later and holds until the next read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readdata <= '0;
        end else if (rd_en) begin
            readdata <= rd_mux;
        end
    end

    a_no_rw_collision: assert property (@(posedge clk) disable iff (rst)
        chipselect |-> !(read && write));

endmodule

`default_nettype wire

/* rtl/admm_projection_lane.sv */
`timescale 1ns/1ps
`default_nettype none
`include "admm_params.svh"

module admm_projection_lane (
    input  logic                clk,
    input  logic                rst,
    input  logic                clear,
    input  logic                step,
    input  admm_pkg::lane_cfg_t cfg,
    output admm_pkg::lane_out_t lane_out,
    output logic                lane_valid
);
    import admm_pkg::*;

    localparam int W = `ADMM_DATA_W;

    typedef logic signed [W:0]   wide_t;
    typedef logic signed [W+1:0] wider_t;

    wide_t          sum;
    wide_t          dz;
    wide_t          abs_dz;
    wider_t         y_wide;
    fix_t           z_new;
    fix_t           y_new;

    always_comb begin
        // u + y with one guard bit, then box projection
        sum = wide_t'(cfg.u) + wide_t'(lane_out.y);
        if (sum < wide_t'(cfg.u_min)) begin
            z_new = cfg.u_min;
        end else if (sum > wide_t'(cfg.u_max)) begin
            z_new = cfg.u_max;
        end else begin
            z_new = fix_t'(sum);
        end

        // Dual update saturates to the fix_t range
        y_wide = wider_t'(sum) - wider_t'(z_new);
        if (y_wide > wider_t'(FIX_MAX)) begin
            y_new = FIX_MAX;
        end else if (y_wide < wider_t'(FIX_MIN)) begin
            y_new = FIX_MIN;
        end else begin
            y_new = fix_t'(y_wide);
        end

        dz     = wide_t'(z_new) - wide_t'(lane_out.z);
        abs_dz = dz[W] ? -dz : dz;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lane_out   <= '0;
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= step;
            if (clear) begin
                lane_out <= '0;
            end else if (step) begin
                lane_out.z        <= z_new;
                lane_out.y        <= y_new;
                lane_out.residual <= abs_dz[W-1:0];
            end
        end
    end

    a_z_in_box: assert property (@(posedge clk) disable iff (rst)
        lane_valid && (cfg.u_min <= cfg.u_max)
        |-> (lane_out.z >= cfg.u_min) && (lane_out.z <= cfg.u_max));

endmodule

`default_nettype wire

/* rtl/admm_residual_check.sv */
`timescale 1ns/1ps
`default_nettype none
`include "admm_params.svh"

module admm_residual_check (
    input  logic                    clk,
    input  logic                    rst,
    input  admm_pkg::lane_out_t     lane_out [`ADMM_LANES],
    input  logic [`ADMM_LANES-1:0]  lane_valid,
    input  admm_pkg::fix_t          tol,
    output admm_pkg::fix_t          max_res,
    output logic                    converged,
    output logic                    check_valid
);
    import admm_pkg::*;

    logic [`ADMM_DATA_W-1:0] max_u;
    fix_t                    max_sat;

    always_comb begin
        max_u = '0;
        for (int i = 0; i < `ADMM_LANES; i++) begin
            if (lane_out[i].residual > max_u) begin
                max_u = lane_out[i].residual;
            end
        end
        // Clip to the largest positive fix_t
        if (max_u > FIX_MAX) begin
            max_sat = FIX_MAX;
        end else begin
            max_sat = fix_t'(max_u);
        end
    end

    // Lanes run in lockstep, lane 0 paces the check
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            max_res     <= '0;
            converged   <= 1'b0;
            check_valid <= 1'b0;
        end else begin
            check_valid <= lane_valid[0];
            if (lane_valid[0]) begin
                max_res   <= max_sat;
                converged <= (max_sat <= tol);
            end
        end
    end

    a_lanes_lockstep: assert property (@(posedge clk) disable iff (rst)
        lane_valid[0] |-> (&lane_valid));

endmodule

`default_nettype wire

/* rtl/admm_controller.sv */
`timescale 1ns/1ps
`default_nettype none
`include "admm_params.svh"

module admm_controller (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       check_valid,
    input  logic       converged,
    output logic       clear,
    output logic       step,
    output logic       busy,
    output logic       done,
    output logic       conv_flag,
    output logic [7:0] iter
);
    import admm_pkg::*;

    solver_state_t state;
    solver_state_t state_next;
    logic          at_limit;

    assign at_limit = (iter >= 8'(`ADMM_MAX_ITER));

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (start) state_next = INIT;
            INIT:    state_next = STEP;
            STEP:    state_next = WAIT;
            WAIT:    if (check_valid) state_next = CHECK;
            CHECK: begin
                if (converged || at_limit) begin
                    state_next = DONE;
                end else begin
                    state_next = STEP;
                end
            end
            DONE:    if (!start) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Iteration count and result flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iter      <= '0;
            conv_flag <= 1'b0;
        end else begin
            case (state)
                INIT: begin
                    iter      <= '0;
                    conv_flag <= 1'b0;
                end
                WAIT:    if (check_valid) iter <= iter + 8'd1;
                CHECK:   conv_flag <= converged;
                default: ;
            endcase
        end
    end

    assign clear = (state == INIT);
    assign step  = (state == STEP);
    assign busy  = (state inside {INIT, STEP, WAIT, CHECK});
    assign done  = (state == DONE);

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(clear && step));

    // Lane and check pipeline answers in exactly two cycles
    a_check_latency: assert property (@(posedge clk) disable iff (rst)
        step |-> ##2 check_valid);

endmodule

`default_nettype wire

/* rtl/admm_solver.sv */
`timescale 1ns/1ps
`default_nettype none
`include "admm_params.svh"

module admm_solver (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`ADMM_BUS_W-1:0]  writedata,
    input  logic                    read,
    input  logic                    write,
    input  logic                    chipselect,
    input  logic [`ADMM_ADDR_W-1:0] addr,
    output logic [`ADMM_BUS_W-1:0]  readdata
);
    import admm_pkg::*;

    lane_cfg_t              cfg [`ADMM_LANES];
    lane_out_t              lane_out [`ADMM_LANES];
    logic [`ADMM_LANES-1:0] lane_valid;
    fix_t                   tol;
    fix_t                   max_res;
    logic                   start;
    logic                   clear;
    logic                   step;
    logic                   busy;
    logic                   done;
    logic                   converged;
    logic                   conv_flag;
    logic                   check_valid;
    logic [7:0]             iter;

    admm_regs regs_i (
        .clk        (clk),
        .rst        (rst),
        .writedata  (writedata),
        .read       (read),
        .write      (write),
        .chipselect (chipselect),
        .addr       (addr),
        .readdata   (readdata),
        .cfg        (cfg),
        .lane_out   (lane_out),
        .tol        (tol),
        .max_res    (max_res),
        .start      (start),
        .done       (done),
        .converged  (conv_flag),
        .busy       (busy),
        .iter       (iter)
    );

    for (genvar i = 0; i < `ADMM_LANES; i++) begin : g_lane
        admm_projection_lane lane_i (
            .clk        (clk),
            .rst        (rst),
            .clear      (clear),
            .step       (step),
            .cfg        (cfg[i]),
            .lane_out   (lane_out[i]),
            .lane_valid (lane_valid[i])
        );
    end

    admm_residual_check check_i (
        .clk         (clk),
        .rst         (rst),
        .lane_out    (lane_out),
        .lane_valid  (lane_valid),
        .tol         (tol),
        .max_res     (max_res),
        .converged   (converged),
        .check_valid (check_valid)
    );

    admm_controller ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .check_valid (check_valid),
        .converged   (converged),
        .clear       (clear),
        .step        (step),
        .busy        (busy),
        .done        (done),
        .conv_flag   (conv_flag),
        .iter        (iter)
    );

endmodule

`default_nettype wire

/* tests/admm_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "admm_params.svh"

module admm_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    chipselect,
    input  logic                    read,
    input  logic                    write,
    input  logic [`ADMM_ADDR_W-1:0] addr,
    input  logic [`ADMM_BUS_W-1:0]  writedata,
    input  logic [`ADMM_BUS_W-1:0]  readdata,
    output int                      checks,
    output int                      errors
);
    import admm_pkg::*;

    localparam int FAR = 1 << 30;

    // Register and solver model
    fix_t                   ctrl_m;
    fix_t                   tol_m;
    lane_cfg_t              cfg_m [`ADMM_LANES];
    fix_t                   z_m [`ADMM_LANES];
    fix_t                   y_m [`ADMM_LANES];
    int                     iter_m;
    int                     resid_m;
    logic                   conv_m;
    logic                   prev_conv;

    // Cycle stamps of the current solve
    int                     cyc;
    int                     t_start;
    int                     t_done;
    int                     t_clear;

    logic                   rd_pend;
    logic [`ADMM_BUS_W-1:0] rd_exp;
    string                  rd_name;

    initial begin
        checks = 0;
        errors = 0;
        cyc    = 0;
    end

    task automatic reset_model();
        ctrl_m    = '0;
        // Tolerance after reset, 1/16
        tol_m     = fix_t'(16);
        iter_m    = 0;
        resid_m   = 0;
        conv_m    = 1'b0;
        prev_conv = 1'b0;
        t_start   = -100;
        t_done    = -100;
        t_clear   = -100;
        rd_pend   = 1'b0;
        for (int i = 0; i < `ADMM_LANES; i++) begin
            cfg_m[i] = '0;
            z_m[i]   = '0;
            y_m[i]   = '0;
        end
    endtask

    // Controller state as seen by the bus at cycle tr
    function automatic solver_state_t state_at(int tr);
        if (tr <= t_start + 1 || tr > t_clear + 1) begin
            return IDLE;
        end
        if (tr == t_start + 2) begin
            return INIT;
        end
        if (tr > t_done) begin
            return DONE;
        end
        case ((tr - t_start - 3) % 4)
            0:       return STEP;
            3:       return CHECK;
            default: return WAIT;
        endcase
    endfunction

    function automatic string addr_name(reg_addr_u a);
        string f;
        if (!a.ctrl.region) begin
            case (a.ctrl.num)
                `ADMM_REG_CTRL:  return "CTRL";
                `ADMM_REG_ITER:  return "ITER";
                `ADMM_REG_TOL:   return "TOL";
                `ADMM_REG_RESID: return "RESID";
                default:         return "unmapped register";
            endcase
        end
        case (a.lane.field)
            `ADMM_FLD_U:    f = "U";
            `ADMM_FLD_UMIN: f = "UMIN";
            `ADMM_FLD_UMAX: f = "UMAX";
            `ADMM_FLD_Z:    f = "Z";
            `ADMM_FLD_Y:    f = "Y";
            default:        f = "unmapped field";
        endcase
        return $sformatf("lane %0d %s", a.lane.index, f);
    endfunction

    // Projection, dual update and residual, repeated until converged
    task automatic start_solve();
        int sum;
        int zn;
        int yn;
        int dz;
        int mx;
        prev_conv = conv_m;
        t_start   = cyc;
        t_clear   = FAR;
        iter_m    = 0;
        mx        = 0;
        for (int i = 0; i < `ADMM_LANES; i++) begin
            z_m[i] = '0;
            y_m[i] = '0;
        end
        do begin
            mx = 0;
            for (int i = 0; i < `ADMM_LANES; i++) begin
                sum = int'(cfg_m[i].u) + int'(y_m[i]);
                zn  = sum;
                if (sum < int'(cfg_m[i].u_min)) begin
                    zn = int'(cfg_m[i].u_min);
                end else if (sum > int'(cfg_m[i].u_max)) begin
                    zn = int'(cfg_m[i].u_max);
                end
                yn = sum - zn;
                if (yn > int'(FIX_MAX)) begin
                    yn = int'(FIX_MAX);
                end else if (yn < int'(FIX_MIN)) begin
                    yn = int'(FIX_MIN);
                end
                dz = zn - int'(z_m[i]);
                if (dz < 0) begin
                    dz = -dz;
                end
                if (dz > mx) begin
                    mx = dz;
                end
                z_m[i] = fix_t'(zn);
                y_m[i] = fix_t'(yn);
            end
            if (mx > int'(FIX_MAX)) begin
                mx = int'(FIX_MAX);
            end
            iter_m++;
            conv_m = (mx <= int'(tol_m));
        end while (!conv_m && iter_m < `ADMM_MAX_ITER);
        resid_m = mx;
        t_done  = t_start + 2 + 4 * iter_m;
    endtask

    task automatic expect_read();
        reg_addr_u     a;
        solver_state_t st;
        logic          conv_e;
        logic          busy_e;
        int            idx;
        a       = addr;
        st      = state_at(cyc);
        idx     = int'(a.lane.index);
        rd_exp  = '0;
        rd_name = addr_name(a);
        if (!a.ctrl.region) begin
            case (a.ctrl.num)
                `ADMM_REG_CTRL:  rd_exp = int'(ctrl_m);
                `ADMM_REG_ITER:  rd_exp = iter_m;
                `ADMM_REG_TOL:   rd_exp = int'(tol_m);
                `ADMM_REG_RESID: rd_exp = resid_m;
                `ADMM_REG_STATUS: begin
                    if (cyc > t_done) begin
                        conv_e = conv_m;
                    end else if (cyc >= t_start + 3) begin
                        conv_e = 1'b0;
                    end else begin
                        conv_e = prev_conv;
                    end
                    busy_e  = st inside {INIT, STEP, WAIT, CHECK};
                    rd_exp  = {29'd0, busy_e, conv_e, st == DONE};
                    rd_name = $sformatf("STATUS in %s", st.name());
                end
                default: ;
            endcase
        end else if (idx < `ADMM_LANES) begin
            case (a.lane.field)
                `ADMM_FLD_U:    rd_exp = int'(cfg_m[idx].u);
                `ADMM_FLD_UMIN: rd_exp = int'(cfg_m[idx].u_min);
                `ADMM_FLD_UMAX: rd_exp = int'(cfg_m[idx].u_max);
                `ADMM_FLD_Z:    rd_exp = int'(z_m[idx]);
                `ADMM_FLD_Y:    rd_exp = int'(y_m[idx]);
                default: ;
            endcase
        end
    endtask

    task automatic apply_write();
        reg_addr_u a;
        fix_t      d;
        int        idx;
        a   = addr;
        d   = writedata[`ADMM_DATA_W-1:0];
        idx = int'(a.lane.index);
        if (!a.ctrl.region) begin
            if (a.ctrl.num == `ADMM_REG_TOL) begin
                tol_m = d;
            end else if (a.ctrl.num == `ADMM_REG_CTRL) begin
                if (d[0] && !ctrl_m[0]) begin
                    start_solve();
                end else if (!d[0] && ctrl_m[0]) begin
                    t_clear = cyc;
                end
                ctrl_m = d;
            end
        end else if (idx < `ADMM_LANES && !(state_at(cyc) inside {INIT, STEP, WAIT, CHECK})) begin
            case (a.lane.field)
                `ADMM_FLD_U:    cfg_m[idx].u     = d;
                `ADMM_FLD_UMIN: cfg_m[idx].u_min = d;
                `ADMM_FLD_UMAX: cfg_m[idx].u_max = d;
                default: ;
            endcase
        end
    endtask

    // Read data from the previous cycle is compared before new traffic
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rst) begin
            reset_model();
        end else begin
            if (rd_pend) begin
                checks++;
                if (readdata !== rd_exp) begin
                    errors++;
                    $display("[FAIL] %s: expected %h, actual %h", rd_name, rd_exp, readdata);
                end
            end
            rd_pend = chipselect && read;
            if (rd_pend) begin
                expect_read();
            end
            if (chipselect && write) begin
                apply_write();
            end
        end
    end

endmodule

`default_nettype wire

/* tests/admm_solver_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "admm_params.svh"

module admm_solver_tb;
    import admm_pkg::*;

    localparam int NUM_SOLVES   = 20;
    // Roughly 45 bus accesses per solve, plus a solve at the iteration limit
    localparam int BUS_CYCLES   = 80;
    localparam int SOLVE_CYCLES = 4 * `ADMM_MAX_ITER + 2;
    localparam int MAX_CYCLES   = NUM_SOLVES * (BUS_CYCLES + SOLVE_CYCLES) + 200;

    logic                   clk;
    logic                   rst;
    logic [`ADMM_BUS_W-1:0] writedata;
    logic                   read;
    logic                   write;
    logic                   chipselect;
    logic [`ADMM_ADDR_W-1:0] addr;
    logic [`ADMM_BUS_W-1:0] readdata;

    int seed;
    int cycles;
    int chk_count;
    int chk_errors;

    admm_solver admm_solver_i (
        .clk        (clk),
        .rst        (rst),
        .writedata  (writedata),
        .read       (read),
        .write      (write),
        .chipselect (chipselect),
        .addr       (addr),
        .readdata   (readdata)
    );

    admm_checker checker_i (
        .clk        (clk),
        .rst        (rst),
        .chipselect (chipselect),
        .read       (read),
        .write      (write),
        .addr       (addr),
        .writedata  (writedata),
        .readdata   (readdata),
        .checks     (chk_count),
        .errors     (chk_errors)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the solver never raised done", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic int rand_below(int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // Uniform over -64.0 to +64.0
    function automatic fix_t rand_fix();
        return fix_t'(rand_below(32769) - 16384);
    endfunction

    function automatic logic [`ADMM_ADDR_W-1:0] lane_addr(int lane, int field);
        reg_addr_u a;
        a.lane.region = 1'b1;
        a.lane.index  = lane[`ADMM_ADDR_W-2-`ADMM_FIELD_W:0];
        a.lane.field  = field[`ADMM_FIELD_W-1:0];
        return a;
    endfunction

    task automatic bus_write(input logic [`ADMM_ADDR_W-1:0] a, input logic [31:0] d);
        chipselect = 1'b1;
        write      = 1'b1;
        addr       = a;
        writedata  = d;
        @(posedge clk);
        #1;
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    task automatic bus_read(input logic [`ADMM_ADDR_W-1:0] a, output logic [31:0] d);
        chipselect = 1'b1;
        read       = 1'b1;
        addr       = a;
        @(posedge clk);
        #1;
        chipselect = 1'b0;
        read       = 1'b0;
        d          = readdata;
    endtask

    task automatic wait_done();
        logic [31:0] d;
        d = '0;
        while (!d[0]) begin
            bus_read(8'(`ADMM_REG_STATUS), d);
        end
    endtask

    // Registers read their reset values before any solve
    task automatic read_reset_values();
        logic [31:0] d;
        bus_read(8'(`ADMM_REG_STATUS), d);
        bus_read(8'(`ADMM_REG_ITER), d);
        bus_read(8'(`ADMM_REG_RESID), d);
        bus_read(8'(`ADMM_REG_TOL), d);
    endtask

    // Even solves keep u inside its box, odd ones draw it freely
    task automatic run_solve(input int n);
        fix_t        a;
        fix_t        b;
        fix_t        lo;
        fix_t        hi;
        fix_t        u;
        logic [31:0] d;
        for (int i = 0; i < `ADMM_LANES; i++) begin
            a  = rand_fix();
            b  = rand_fix();
            lo = (a < b) ? a : b;
            hi = (a < b) ? b : a;
            if (n % 2 == 0) begin
                u = fix_t'(int'(lo) + rand_below(int'(hi) - int'(lo) + 1));
            end else begin
                u = rand_fix();
            end
            bus_write(lane_addr(i, `ADMM_FLD_U), {16'($random(seed)), u});
            bus_write(lane_addr(i, `ADMM_FLD_UMIN), {16'($random(seed)), lo});
            bus_write(lane_addr(i, `ADMM_FLD_UMAX), {16'($random(seed)), hi});
        end
        if (n % 4 == 0) begin
            d = 32'd0;
        end else if (n % 4 == 3) begin
            // A negative tolerance never converges, so the solve runs to the limit
            d = 32'(-1 - rand_below(512));
        end else begin
            d = 32'(rand_below(512));
        end
        bus_write(8'(`ADMM_REG_TOL), d);
        for (int i = 0; i < `ADMM_LANES; i++) begin
            for (int f = `ADMM_FLD_U; f <= `ADMM_FLD_UMAX; f++) begin
                bus_read(lane_addr(i, f), d);
            end
        end
        bus_read(8'(`ADMM_REG_TOL), d);
        bus_read(8'(`ADMM_REG_CTRL), d);
        bus_write(8'(`ADMM_REG_CTRL), 32'd1);
        bus_read(8'(`ADMM_REG_CTRL), d);
        // Lane writes during a solve are dropped
        bus_write(lane_addr(0, `ADMM_FLD_U), 32'(rand_fix()));
        wait_done();
        bus_read(8'(`ADMM_REG_ITER), d);
        bus_read(8'(`ADMM_REG_RESID), d);
        for (int i = 0; i < `ADMM_LANES; i++) begin
            bus_read(lane_addr(i, `ADMM_FLD_Z), d);
            bus_read(lane_addr(i, `ADMM_FLD_Y), d);
        end
        bus_read(lane_addr(0, `ADMM_FLD_U), d);
        // Done must hold until start drops
        bus_read(8'(`ADMM_REG_STATUS), d);
        bus_write(8'(`ADMM_REG_CTRL), 32'd0);
        bus_read(8'(`ADMM_REG_STATUS), d);
        bus_read(8'(`ADMM_REG_STATUS), d);
    endtask

    initial begin
        seed       = 32'h004c_9765;
        cycles     = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        read       = 1'b0;
        write      = 1'b0;
        chipselect = 1'b0;
        addr       = '0;
        writedata  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        read_reset_values();
        for (int n = 0; n < NUM_SOLVES; n++) begin
            run_solve(n);
        end
        // Let the checker see the last read
        @(posedge clk);
        #1;
        $display("Solves: %0d, read checks: %0d, errors: %0d", NUM_SOLVES, chk_count, chk_errors);
        if (chk_errors == 0 && chk_count > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* admm_solver.f */
+incdir+rtl
rtl/admm_pkg.sv
rtl/admm_regs.sv
rtl/admm_projection_lane.sv
rtl/admm_residual_check.sv
rtl/admm_controller.sv
rtl/admm_solver.sv
tests/admm_checker.sv
tests/admm_solver_tb.sv

/* Makefile */
TOP = admm_solver_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert --top-module $(TOP) -f admm_solver.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f admm_solver.f

clean:
	rm -rf obj_dir $(LOG)
